// File: compile.f
+incdir+rtl
rtl/div_data_pkg.sv
rtl/div_ctrl_pkg.sv
rtl/div_operand_decode.sv
rtl/div_step_execute.sv
rtl/div_result_ctrl.sv
rtl/div_top.sv
sim/div_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module div_tb -f compile.f -o div_sim \
    && ./obj_dir/div_sim 2>&1 | tee sim.log \
    || echo "build or simulation did not complete"

grep -q "^NO ERRORS$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    && exit 0 \
    || echo "simulation failed"
exit 1

// File: sim/div_tb.sv
// one division at a time through both handshakes; random operands repeat from the fixed seed
`timescale 1ns/10ps

module div_tb
    import div_data_pkg::*;
();

    localparam realtime clock_period = 4.0;
    localparam realtime drive_delay = 0.5;
    localparam int reset_cycles = 4;
    localparam int expected_latency = 9;
    localparam int random_count = 200;
    // 6 sign cases, 3 zero divisors, 3 edge words, 2 timing runs, then the random pairs
    localparam int num_divisions = 14 + random_count;
    localparam int cycles_per_division = 20;
    localparam int margin_cycles = 100;
    localparam realtime watchdog_time =
        (num_divisions * cycles_per_division + margin_cycles + reset_cycles) * clock_period;

    logic  clock = 1'b0;
    logic  arst_n;
    logic  in_valid;
    logic  in_ready;
    word_t dividend;
    word_t divisor;
    logic  out_valid;
    logic  out_ready;
    word_t quotient;
    word_t remainder;
    logic  divide_by_zero;

    integer seed = 32'h9cf3;
    // operands of the division under test, shown in error lines
    word_t  cur_a;
    word_t  cur_b;

    always #(clock_period / 2.0) clock = ~clock;

    div_top u_dut (
        .clock          (clock),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .dividend       (dividend),
        .divisor        (divisor),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .quotient       (quotient),
        .remainder      (remainder),
        .divide_by_zero (divide_by_zero)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h (operands 0x%h / 0x%h)",
                     name, actual, expected, cur_a, cur_b);
            $display("ERRORS FOUND");
            $fatal(1, "first mismatch, run stopped");
        end
    endtask

    // all stimulus changes land a little after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #(drive_delay);
    endtask

    // truncating division from magnitudes, then the sign rules
    task automatic reference_divide(input word_t a, input word_t b, output word_t q,
                                    output word_t r, output logic dz);
        int a_int;
        int b_int;
        int mag_a;
        int mag_b;
        int q_int;
        int r_int;
        a_int = int'($signed(a));
        b_int = int'($signed(b));
        if (b_int == 0) begin
            dz = 1'b1;
            r_int = a_int;
            q_int = (a_int >= 0) ? -1 : 1;
        end else begin
            dz = 1'b0;
            mag_a = (a_int < 0) ? -a_int : a_int;
            mag_b = (b_int < 0) ? -b_int : b_int;
            q_int = mag_a / mag_b;
            r_int = mag_a % mag_b;
            if ((a_int < 0) != (b_int < 0)) begin
                q_int = -q_int;
            end
            // remainder follows the dividend
            if (a_int < 0) begin
                r_int = -r_int;
            end
        end
        // cut to the word, so 128 wraps to -128
        q = q_int[7:0];
        r = r_int[7:0];
    endtask

    // one full transfer, holding out_ready low for hold cycles once out_valid is up
    task automatic run_division(input word_t a, input word_t b, input int hold,
                                output word_t q, output word_t r, output logic dz,
                                output int latency);
        word_t held_q;
        word_t held_r;
        logic  held_dz;
        cur_a = a;
        cur_b = b;
        in_valid = 1'b1;
        dividend = a;
        divisor = b;
        while (!in_ready) begin
            next_cycle();
        end
        // accepting edge
        next_cycle();
        in_valid = 1'b0;
        // junk on the data inputs, they only matter at the transfer
        dividend = 8'($random(seed));
        divisor = 8'($random(seed));
        latency = 0;
        while (!out_valid) begin
            check_value("in_ready", 32'(in_ready), 32'd0);
            next_cycle();
            latency++;
        end
        check_value("in_ready", 32'(in_ready), 32'd0);
        held_q = quotient;
        held_r = remainder;
        held_dz = divide_by_zero;
        repeat (hold) begin
            next_cycle();
            check_value("out_valid", 32'(out_valid), 32'd1);
            check_value("in_ready", 32'(in_ready), 32'd0);
            check_value("quotient", 32'(quotient), 32'(held_q));
            check_value("remainder", 32'(remainder), 32'(held_r));
            check_value("divide_by_zero", 32'(divide_by_zero), 32'(held_dz));
        end
        out_ready = 1'b1;
        q = quotient;
        r = remainder;
        dz = divide_by_zero;
        // output transfer
        next_cycle();
        out_ready = 1'b0;
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("in_ready", 32'(in_ready), 32'd1);
    endtask

    task automatic divide_and_check(input word_t a, input word_t b, input word_t exp_q,
                                    input word_t exp_r, input logic exp_dz, input int hold);
        word_t q;
        word_t r;
        logic  dz;
        int    latency;
        run_division(a, b, hold, q, r, dz, latency);
        check_value("latency", 32'(latency), 32'(expected_latency));
        check_value("quotient", 32'(q), 32'(exp_q));
        check_value("remainder", 32'(r), 32'(exp_r));
        check_value("divide_by_zero", 32'(dz), 32'(exp_dz));
    endtask

    task automatic check_after_reset();
        check_value("in_ready", 32'(in_ready), 32'd1);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("divide_by_zero", 32'(divide_by_zero), 32'd0);
    endtask

    task automatic sign_table();
        divide_and_check(8'd22, 8'd7, 8'd3, 8'd1, 1'b0, 0);
        divide_and_check(8'(-22), 8'd7, 8'(-3), 8'(-1), 1'b0, 0);
        divide_and_check(8'd22, 8'(-7), 8'(-3), 8'd1, 1'b0, 0);
        divide_and_check(8'(-22), 8'(-7), 8'd3, 8'(-1), 1'b0, 0);
        divide_and_check(8'd7, 8'd22, 8'd0, 8'd7, 1'b0, 0);
        divide_and_check(8'(-7), 8'd22, 8'd0, 8'(-7), 1'b0, 0);
    endtask

    task automatic zero_divisor();
        divide_and_check(8'd0, 8'd0, 8'(-1), 8'd0, 1'b1, 0);
        divide_and_check(8'd22, 8'd0, 8'(-1), 8'd22, 1'b1, 0);
        divide_and_check(8'(-22), 8'd0, 8'd1, 8'(-22), 1'b1, 0);
    endtask

    task automatic edge_words();
        divide_and_check(8'h80, 8'hff, 8'h80, 8'd0, 1'b0, 0);
        divide_and_check(8'h80, 8'd1, 8'h80, 8'd0, 1'b0, 0);
        divide_and_check(8'd127, 8'h80, 8'd0, 8'd127, 1'b0, 0);
    endtask

    // latency is checked in every run, these two add held results
    task automatic back_pressure();
        divide_and_check(8'd100, 8'(-9), 8'(-11), 8'd1, 1'b0, 1);
        divide_and_check(8'(-77), 8'd5, 8'(-15), 8'(-2), 1'b0, 6);
    endtask

    task automatic random_operands();
        word_t a;
        word_t b;
        word_t exp_q;
        word_t exp_r;
        logic  exp_dz;
        int    hold;
        for (int i = 0; i < random_count; i++) begin
            a = 8'($random(seed));
            b = 8'($random(seed));
            hold = int'($random(seed) & 32'sd3);
            reference_divide(a, b, exp_q, exp_r, exp_dz);
            divide_and_check(a, b, exp_q, exp_r, exp_dz, hold);
        end
    endtask

    // bound from the number of divisions above
    initial begin
        #(watchdog_time);
        $display("Timeout: the divisions did not all complete in the expected time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        arst_n = 1'b0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        dividend = '0;
        divisor = '0;
        cur_a = '0;
        cur_b = '0;
        repeat (reset_cycles) @(posedge clock);
        #(drive_delay);
        arst_n = 1'b1;
        check_after_reset();
        sign_table();
        zero_divisor();
        edge_words();
        back_pressure();
        random_operands();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: rtl/div_top.sv
// 8-bit signed divider truncating toward zero; 9 cycles from input transfer to out_valid
`timescale 1ns/10ps

module div_top
    import div_data_pkg::*;
    import div_ctrl_pkg::*;
(
    input  logic  clock,
    input  logic  arst_n,

    // operand side
    input  logic  in_valid,
    output logic  in_ready,
    input  word_t dividend,
    input  word_t divisor,

    // result side
    output logic  out_valid,
    input  logic  out_ready,
    output word_t quotient,
    output word_t remainder,
    output logic  divide_by_zero
);

    // load and step strobes from the FSM
    div_ctrl_t  ctrl;
    div_load_t  load_vals;
    div_signs_t signs;
    div_acc_t   acc;

    div_operand_decode u_decode (
        .clock          (clock),
        .arst_n         (arst_n),
        .dividend       (dividend),
        .divisor        (divisor),
        .ctrl           (ctrl),
        .load_vals      (load_vals),
        .signs          (signs),
        .divide_by_zero (divide_by_zero)
    );

    div_step_execute u_execute (
        .clock     (clock),
        .arst_n    (arst_n),
        .ctrl      (ctrl),
        .load_vals (load_vals),
        .signs     (signs),
        .acc       (acc)
    );

    // FSM, step counter and both handshakes
    div_result_ctrl u_result (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .acc       (acc),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .ctrl      (ctrl),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

// File: rtl/div_result_ctrl.sv
// one division in flight at a time; results are the low word bits, so overflow wraps (-128/-1 = -128)
`timescale 1ns/10ps
`include "div_macros.svh"

module div_result_ctrl
    import div_data_pkg::*;
    import div_ctrl_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    input  logic      in_valid,
    input  logic      out_ready,
    input  div_acc_t  acc,
    output logic      in_ready,
    output logic      out_valid,
    output div_ctrl_t ctrl,
    output word_t     quotient,
    output word_t     remainder
);

    // count value of the first step
    localparam logic [`DIV_STEP_BITS-1:0] step_first = `DIV_STEPS - 1;

    div_state_e state;
    div_state_e state_next;
    // steps left after the current one
    logic [`DIV_STEP_BITS-1:0] step_count;
    logic out_fire;
    logic last_step;

    always_comb begin
        in_ready  = (state == LOAD);
        out_valid = (state == DONE);

        ctrl.load = in_ready && in_valid;
        ctrl.step = (state == CALC);
        out_fire  = out_valid && out_ready;
        last_step = ctrl.step && (step_count == '0);

        state_next = state;
        case (state)
            LOAD: if (ctrl.load) state_next = CALC;
            CALC: if (last_step) state_next = DONE;
            DONE: if (out_fire) state_next = LOAD;
            default: state_next = LOAD;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= LOAD;
            step_count <= '0;
        end else begin
            state <= state_next;
            if (ctrl.load) begin
                step_count <= step_first;
            end else if (ctrl.step && !last_step) begin
                step_count <= step_count - 1'b1;
            end
        end
    end

    // accumulators only change in CALC, so these hold through DONE
    assign quotient  = acc.quotient_long[`DIV_WORD_WIDTH-1:0];
    assign remainder = acc.remainder_long[`DIV_WORD_WIDTH-1:0];

    // out_valid is first sampled high DIV_STEPS+1 edges after the load edge
    a_latency: assert property (
        @(posedge clock) disable iff (!arst_n)
        $rose(out_valid) |-> $past(ctrl.load, `DIV_STEPS + 1)
    );

    // results stay put under back-pressure
    a_out_hold: assert property (
        @(posedge clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(quotient) && $stable(remainder)
    );

endmodule

// File: rtl/div_step_execute.sv
// accumulators are valid only after a full run of DIV_STEPS steps; they hold unknown values after reset
`timescale 1ns/10ps
`include "div_macros.svh"

module div_step_execute
    import div_data_pkg::*;
    import div_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  div_ctrl_t  ctrl,
    input  div_load_t  load_vals,
    input  div_signs_t signs,
    output div_acc_t   acc
);

    // quotient increment for the first step, a one at the highest shift
    localparam wide_t quo_inc_init = wide_t'(1) << `DIV_WORD_WIDTH;

    long_t remainder_q;
    long_t quotient_q;
    // divisor times the current power of two
    wide_t rem_inc;
    // current power of two
    wide_t quo_inc;

    long_t remainder_next;
    long_t quotient_next;
    // remainder extended to the increment width
    wide_t rem_wide;
    wide_t trial;
    logic  signs_differ;
    logic  overshoot;

    always_comb begin
        signs_differ = signs.dividend_sign ^ signs.divisor_sign;

        // done at full width so the large early increments cannot wrap
        rem_wide = {{(`DIV_WIDE_WIDTH - `DIV_LONG_WIDTH){remainder_q[`DIV_LONG_WIDTH-1]}},
                    remainder_q};

        // always move the remainder toward zero
        if (signs_differ) begin
            trial = rem_wide + rem_inc;
        end else begin
            trial = rem_wide - rem_inc;
        end

        // crossing zero to the other sign means the step took too much
        // landing exactly on zero is fine
        overshoot = (trial[`DIV_WIDE_WIDTH-1] != signs.dividend_sign) && (trial != '0);

        // a kept trial is no larger than the old remainder, so it fits
        remainder_next = trial[`DIV_LONG_WIDTH-1:0];

        // quotient wraps modulo 2^9
        // this is what makes divide by zero come out as -1 or +1
        if (signs_differ) begin
            quotient_next = quotient_q - quo_inc[`DIV_LONG_WIDTH-1:0];
        end else begin
            quotient_next = quotient_q + quo_inc[`DIV_LONG_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.load) begin
            remainder_q <= load_vals.dividend_long;
            quotient_q  <= '0;
            rem_inc     <= load_vals.divisor_wide;
            quo_inc     <= quo_inc_init;
        end else if (ctrl.step) begin
            if (!overshoot) begin
                remainder_q <= remainder_next;
                quotient_q  <= quotient_next;
            end
            // arithmetic shift keeps a negative divisor negative
            rem_inc <= {rem_inc[`DIV_WIDE_WIDTH-1], rem_inc[`DIV_WIDE_WIDTH-1:1]};
            quo_inc <= {1'b0, quo_inc[`DIV_WIDE_WIDTH-1:1]};
        end
    end

    always_comb begin
        acc.quotient_long  = quotient_q;
        acc.remainder_long = remainder_q;
    end

    // a new load in the middle of a run would corrupt the accumulators
    a_load_step_exclusive: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(ctrl.load && ctrl.step)
    );

endmodule

// File: rtl/div_operand_decode.sv
// signs and the zero flag are held from the load edge until the next load; data inputs matter only then
`timescale 1ns/10ps
`include "div_macros.svh"

module div_operand_decode
    import div_data_pkg::*;
    import div_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  word_t      dividend,
    input  word_t      divisor,
    input  div_ctrl_t  ctrl,
    output div_load_t  load_vals,
    output div_signs_t signs,
    output logic       divide_by_zero
);

    // sign-extended divisor before the shift
    long_t divisor_long;
    // zero test on the raw port word
    logic  divisor_is_zero;

    always_comb begin
        // one extra bit of range so -128 can be negated
        load_vals.dividend_long = {dividend[`DIV_WORD_WIDTH-1], dividend};
        divisor_long            = {divisor[`DIV_WORD_WIDTH-1], divisor};

        // start at the highest shift, execute walks it down one bit per step
        load_vals.divisor_wide  = {divisor_long, {`DIV_WORD_WIDTH{1'b0}}};

        divisor_is_zero         = (divisor == '0);
    end

    // captured once per division, stay valid until the next input transfer
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            signs.dividend_sign <= 1'b0;
            signs.divisor_sign  <= 1'b0;
            divide_by_zero      <= 1'b0;
        end else if (ctrl.load) begin
            signs.dividend_sign <= dividend[`DIV_WORD_WIDTH-1];
            // zero counts as positive here
            // this gives -1 for a non-negative dividend over zero
            signs.divisor_sign  <= divisor[`DIV_WORD_WIDTH-1];
            divide_by_zero      <= divisor_is_zero;
        end
    end

endmodule

// File: rtl/div_ctrl_pkg.sv
// control types for the divider; the state encoding covers three of four codes, 2'b11 never occurs
package div_ctrl_pkg;

    // LOAD waits for operands
    // CALC runs the trial steps
    // DONE holds the results until they are taken
    typedef enum logic [1:0] {
        LOAD = 2'b00,
        CALC = 2'b01,
        DONE = 2'b10
    } div_state_e;

    // strobes from result control to decode and execute
    typedef struct packed {
        // input transfer, operands are sampled on this edge
        logic load;
        // one trial step per cycle while in CALC
        logic step;
    } div_ctrl_t;

endpackage

// File: rtl/div_data_pkg.sv
// data path types for the 8-bit divider; internal vectors are signed, port words are plain bits
package div_data_pkg;

    `include "div_macros.svh"

    // operand or result as seen at the ports
    typedef logic [`DIV_WORD_WIDTH-1:0] word_t;

    // dividend, remainder and quotient with the extra sign bit
    typedef logic signed [`DIV_LONG_WIDTH-1:0] long_t;

    // shifted divisor and quotient increment
    typedef logic signed [`DIV_WIDE_WIDTH-1:0] wide_t;

    // operands as prepared by decode, sampled by execute on the load strobe
    typedef struct packed {
        long_t dividend_long;
        // divisor already shifted up by the word width
        wide_t divisor_wide;
    } div_load_t;

    // operand signs captured at load, 1 means negative
    typedef struct packed {
        logic dividend_sign;
        logic divisor_sign;
    } div_signs_t;

    // running results, narrowed to word_t by result control
    typedef struct packed {
        long_t quotient_long;
        long_t remainder_long;
    } div_acc_t;

endpackage

// File: rtl/div_macros.svh
// widths are fixed here for 8-bit words; changing DIV_WORD_WIDTH means updating all derived values by hand
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// width of the operands and results at the ports
`define DIV_WORD_WIDTH 8

// one extra bit so the most negative word has a positive magnitude
`define DIV_LONG_WIDTH 9

// shifted divisor and quotient increment
// twice the word width plus one
`define DIV_WIDE_WIDTH 17

// one trial step per shift, from DIV_WORD_WIDTH down to zero
`define DIV_STEPS 9

// step counter width, must hold DIV_STEPS-1
`define DIV_STEP_BITS 4

`endif
